/* include/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction word and the 20-bit immediate carried with each micro-op
`define INST_W 32
`define IMM_W 20

// architectural register index
`define REG_IDX_W 5

// fetch address space
`define PC_W 32
`define RESET_PC 32'h0000_1000
`define PC_STEP 4

`endif

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes of the supported RV64IM subset
    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111
    } opcode_e;

    // legal funct7 values of register-register ops
    typedef enum logic [6:0] {
        f7_base   = 7'b0000000,
        f7_muldiv = 7'b0000001,
        // sub and sra
        f7_alt    = 7'b0100000
    } funct7_e;

endpackage

`default_nettype wire

/* logic/uarch_pkg.sv */
`default_nettype none
`include "decode_settings.svh"

package uarch_pkg;

    typedef enum logic [3:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_muldiv,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_unknown
    } op_class_e;

    typedef enum logic [5:0] {
        uop_none,
        // alu
        uop_lui, uop_auipc, uop_add, uop_sub, uop_addw, uop_subw,
        uop_sll, uop_srl, uop_sra, uop_sllw, uop_srlw, uop_sraw,
        uop_xor, uop_or, uop_and, uop_slt, uop_sltu,
        // mdu
        uop_mul, uop_mulh, uop_mulhsu, uop_mulhu, uop_mulw,
        uop_div, uop_divu, uop_divw, uop_divuw,
        uop_rem, uop_remu, uop_remw, uop_remuw,
        // bru
        uop_beq, uop_bne, uop_blt, uop_bge, uop_bltu, uop_bgeu, uop_jal, uop_jalr,
        // mem
        uop_lb, uop_lh, uop_lw, uop_ld, uop_lbu, uop_lhu, uop_lwu,
        uop_sb, uop_sh, uop_sw, uop_sd
    } uop_e;

    typedef enum logic [2:0] {
        iq_none,
        iq_alu,
        iq_mdu,
        iq_bru,
        iq_mem
    } issue_queue_e;

    typedef struct packed {
        logic [`PC_W-1:0]   pc;
        logic [`INST_W-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`PC_W-1:0]      pc;
        logic [`IMM_W-1:0]     imm;
        logic [`REG_IDX_W-1:0] rd_idx;
        logic [`REG_IDX_W-1:0] rs1_idx;
        logic [`REG_IDX_W-1:0] rs2_idx;
        logic                  rd_wen;
        logic                  use_imm;
        uop_e                  uop;
        issue_queue_e          queue;
        logic                  unknown;
    } decinfo_t;

endpackage

`default_nettype wire

/* logic/decode_class_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

interface decode_class_if;
    import uarch_pkg::*;

    op_class_e             op_class;
    logic                  is_word;
    logic [2:0]            funct3;
    logic                  funct7_alt;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`INST_W-1:0]    inst;

    modport producer (
        output op_class, is_word, funct3, funct7_alt, rd_idx, rs1_idx, rs2_idx, inst
    );
    modport consumer (
        input op_class, is_word, funct3, funct7_alt, rd_idx, rs1_idx, rs2_idx, inst
    );
endinterface

`default_nettype wire

/* logic/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input wire           i_clk,
    input wire           i_arst_n,
    input wire           i_valid,
    input wire payload_t i_data,
    output logic         o_ready,
    output logic         o_valid,
    output payload_t     o_data,
    input wire           i_ready
);
    // accept when empty or when the entry leaves this cycle
    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            o_data <= i_data;
        end
    end

    // a refused producer must keep offering the same entry
    a_in_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid && !o_ready |=> i_valid && $stable(i_data))
        else $error("input dropped while register was full");

endmodule

`default_nettype wire

/* logic/inst_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module inst_fetch (
    input wire                    i_clk,
    input wire                    i_arst_n,
    input wire [`INST_W-1:0]      i_wb_dat,
    input wire                    i_wb_ack,
    input wire                    i_slot_free,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [`PC_W-1:0]      o_wb_adr,
    output logic                  o_valid,
    output uarch_pkg::fetch_pkt_t o_pkt
);
    logic [`PC_W-1:0] pc;
    logic             busy;

    // one classic cycle at a time, cyc and stb move together
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy <= 1'b0;
            pc <= `RESET_PC;
        end else if (busy) begin
            if (i_wb_ack) begin
                busy <= 1'b0;
                pc <= pc + `PC_W'(`PC_STEP);
            end
        end else if (i_slot_free) begin
            busy <= 1'b1;
        end
    end

    assign o_wb_cyc = busy;
    assign o_wb_stb = busy;
    assign o_wb_adr = pc;

    // the word is taken on the ack edge itself
    assign o_valid = busy && i_wb_ack;
    assign o_pkt.pc = pc;
    assign o_pkt.inst = i_wb_dat;

    // slave may only ack an open cycle
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_ack |-> o_wb_cyc && o_wb_stb)
        else $error("wishbone ack outside a bus cycle");

endmodule

`default_nettype wire

/* logic/inst_classifier.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module inst_classifier (
    input wire uarch_pkg::fetch_pkt_t i_pkt,
    decode_class_if.producer          o_cls
);
    import rv_isa_pkg::*;
    import uarch_pkg::*;

    logic [`INST_W-1:0] inst;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               add_or_sr;
    logic               shift6_ok;
    logic               shift5_ok;
    op_class_e          op_class;

    assign inst = i_pkt.inst;
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign add_or_sr = (funct3 == 3'd0) || (funct3 == 3'd5);

    // rv64 shifts take a 6-bit shamt, only inst[31:26] is funct
    assign shift6_ok = (funct3 == 3'd1) ? (inst[31:26] == 6'b000000)
                     : (funct3 == 3'd5) ? (inst[31:26] inside {6'b000000, 6'b010000})
                     : 1'b1;
    assign shift5_ok = (funct3 == 3'd0)
                     || (funct3 == 3'd1 && funct7 == f7_base)
                     || (funct3 == 3'd5 && (funct7 == f7_base || funct7 == f7_alt));

    // compressed words have inst[1:0] != 2'b11 and match no opcode here
    always_comb begin
        op_class = cls_unknown;
        case (inst[6:0])
            opc_op: begin
                if (funct7 == f7_muldiv) begin
                    op_class = cls_muldiv;
                end else if (funct7 == f7_base || (funct7 == f7_alt && add_or_sr)) begin
                    op_class = cls_alu_reg;
                end
            end
            opc_op_32: begin
                if (funct7 == f7_muldiv && (funct3 == 3'd0 || funct3[2])) begin
                    op_class = cls_muldiv;
                end else if ((funct7 == f7_base && (add_or_sr || funct3 == 3'd1))
                             || (funct7 == f7_alt && add_or_sr)) begin
                    op_class = cls_alu_reg;
                end
            end
            opc_op_imm:    op_class = shift6_ok ? cls_alu_imm : cls_unknown;
            opc_op_imm_32: op_class = shift5_ok ? cls_alu_imm : cls_unknown;
            opc_load:      op_class = (funct3 != 3'd7) ? cls_load : cls_unknown;
            opc_store:     op_class = !funct3[2] ? cls_store : cls_unknown;
            opc_branch:    op_class = (funct3[2:1] != 2'b01) ? cls_branch : cls_unknown;
            opc_jalr:      op_class = (funct3 == 3'd0) ? cls_jalr : cls_unknown;
            opc_jal:       op_class = cls_jal;
            opc_lui:       op_class = cls_lui;
            opc_auipc:     op_class = cls_auipc;
            default:       op_class = cls_unknown;
        endcase
    end

    assign o_cls.op_class = op_class;
    assign o_cls.is_word = (inst[6:0] == opc_op_32) || (inst[6:0] == opc_op_imm_32);
    assign o_cls.funct3 = funct3;
    assign o_cls.funct7_alt = inst[30];
    assign o_cls.rd_idx = inst[11:7];
    assign o_cls.rs1_idx = inst[19:15];
    assign o_cls.rs2_idx = inst[24:20];
    assign o_cls.inst = inst;

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module imm_gen (
    decode_class_if.consumer  i_cls,
    output logic [`IMM_W-1:0] o_imm
);
    import uarch_pkg::*;

    logic [`INST_W-1:0] inst;
    logic [`IMM_W-1:0]  imm_i;
    logic [`IMM_W-1:0]  imm_s;
    logic [`IMM_W-1:0]  imm_b;
    logic [`IMM_W-1:0]  imm_j;
    logic [`IMM_W-1:0]  imm_u;
    logic [`IMM_W-1:0]  imm_sh;
    logic               is_shift;

    assign inst = i_cls.inst;
    assign imm_i = {{(`IMM_W-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`IMM_W-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`IMM_W-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    // jal offset without its sign bit
    assign imm_j = {inst[19:12], inst[20], inst[30:21], 1'b0};
    // upper 20 bits, shifted by the consumer
    assign imm_u = inst[31:12];
    assign imm_sh = {{(`IMM_W-6){1'b0}}, inst[25:20]};

    // slli, srli, srai and their word forms
    assign is_shift = (i_cls.funct3 == 3'd1) || (i_cls.funct3 == 3'd5);

    always_comb begin
        case (i_cls.op_class)
            cls_lui, cls_auipc: o_imm = imm_u;
            cls_alu_imm:        o_imm = is_shift ? imm_sh : imm_i;
            cls_load, cls_jalr: o_imm = imm_i;
            cls_store:          o_imm = imm_s;
            cls_branch:         o_imm = imm_b;
            cls_jal:            o_imm = imm_j;
            default:            o_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/uop_select.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module uop_select (
    decode_class_if.consumer        i_cls,
    output uarch_pkg::uop_e         o_uop,
    output uarch_pkg::issue_queue_e o_queue,
    output logic                    o_rd_wen,
    output logic                    o_use_imm,
    output logic [`REG_IDX_W-1:0]   o_rs1_idx,
    output logic [`REG_IDX_W-1:0]   o_rs2_idx,
    output logic                    o_unknown
);
    import uarch_pkg::*;

    op_class_e    cls;
    logic         word;
    logic         alt;
    logic         sub_sel;
    uop_e         uop;
    issue_queue_e queue;

    assign cls = i_cls.op_class;
    assign word = i_cls.is_word;
    assign alt = i_cls.funct7_alt;
    // inst[30] is an immediate bit for addi, so only the register form subtracts
    assign sub_sel = (cls == cls_alu_reg) && alt;

    always_comb begin
        uop = uop_none;
        case (cls)
            cls_alu_reg, cls_alu_imm: begin
                case (i_cls.funct3)
                    3'd0: uop = sub_sel ? (word ? uop_subw : uop_sub) : (word ? uop_addw : uop_add);
                    3'd1: uop = word ? uop_sllw : uop_sll;
                    3'd2: uop = uop_slt;
                    3'd3: uop = uop_sltu;
                    3'd4: uop = uop_xor;
                    3'd5: uop = alt ? (word ? uop_sraw : uop_sra) : (word ? uop_srlw : uop_srl);
                    3'd6: uop = uop_or;
                    default: uop = uop_and;
                endcase
            end
            cls_muldiv: begin
                case (i_cls.funct3)
                    3'd0: uop = word ? uop_mulw : uop_mul;
                    3'd1: uop = uop_mulh;
                    3'd2: uop = uop_mulhsu;
                    3'd3: uop = uop_mulhu;
                    3'd4: uop = word ? uop_divw : uop_div;
                    3'd5: uop = word ? uop_divuw : uop_divu;
                    3'd6: uop = word ? uop_remw : uop_rem;
                    default: uop = word ? uop_remuw : uop_remu;
                endcase
            end
            cls_branch: begin
                case (i_cls.funct3)
                    3'd0: uop = uop_beq;
                    3'd1: uop = uop_bne;
                    3'd4: uop = uop_blt;
                    3'd5: uop = uop_bge;
                    3'd6: uop = uop_bltu;
                    3'd7: uop = uop_bgeu;
                    default: uop = uop_none;
                endcase
            end
            cls_load: begin
                case (i_cls.funct3)
                    3'd0: uop = uop_lb;
                    3'd1: uop = uop_lh;
                    3'd2: uop = uop_lw;
                    3'd3: uop = uop_ld;
                    3'd4: uop = uop_lbu;
                    3'd5: uop = uop_lhu;
                    3'd6: uop = uop_lwu;
                    default: uop = uop_none;
                endcase
            end
            cls_store: begin
                case (i_cls.funct3)
                    3'd0: uop = uop_sb;
                    3'd1: uop = uop_sh;
                    3'd2: uop = uop_sw;
                    default: uop = uop_sd;
                endcase
            end
            cls_lui:   uop = uop_lui;
            cls_auipc: uop = uop_auipc;
            cls_jal:   uop = uop_jal;
            cls_jalr:  uop = uop_jalr;
            default:   uop = uop_none;
        endcase

        case (cls)
            cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc: queue = iq_alu;
            cls_muldiv:                                    queue = iq_mdu;
            cls_branch, cls_jal, cls_jalr:                 queue = iq_bru;
            cls_load, cls_store:                           queue = iq_mem;
            default:                                       queue = iq_none;
        endcase

        // catches a funct3 that the classifier let through but has no uop
        a_queue_uop: assert ((queue == iq_none) == (uop == uop_none))
            else $error("issue queue and micro-op disagree");
    end

    assign o_uop = uop;
    assign o_queue = queue;
    assign o_rd_wen = !(cls inside {cls_branch, cls_store, cls_unknown})
                      && (i_cls.rd_idx != '0);
    assign o_rs1_idx = (cls inside {cls_lui, cls_auipc, cls_jal, cls_unknown})
                       ? '0 : i_cls.rs1_idx;
    assign o_rs2_idx = (cls inside {cls_alu_reg, cls_muldiv, cls_branch, cls_store})
                       ? i_cls.rs2_idx : '0;
    assign o_use_imm = (cls == cls_alu_imm);
    assign o_unknown = (cls == cls_unknown);

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module decode_stage (
    input wire                       i_clk,
    input wire                       i_arst_n,
    // wishbone classic, read only
    output logic                     o_wb_cyc,
    output logic                     o_wb_stb,
    output logic [`PC_W-1:0]         o_wb_adr,
    input wire [`INST_W-1:0]         i_wb_dat,
    input wire                       i_wb_ack,
    // decoded micro-op stream
    output logic                     o_dec_valid,
    input wire                       i_dec_ready,
    output logic [`PC_W-1:0]         o_dec_pc,
    output logic [`IMM_W-1:0]        o_dec_imm,
    output logic [`REG_IDX_W-1:0]    o_dec_rd_idx,
    output logic [`REG_IDX_W-1:0]    o_dec_rs1_idx,
    output logic [`REG_IDX_W-1:0]    o_dec_rs2_idx,
    output logic                     o_dec_rd_wen,
    output logic                     o_dec_use_imm,
    output uarch_pkg::uop_e          o_dec_uop,
    output uarch_pkg::issue_queue_e  o_dec_queue,
    output logic                     o_dec_unknown
);
    import uarch_pkg::*;

    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       fq_valid;
    fetch_pkt_t fq_pkt;
    logic       dq_ready;
    decinfo_t   dec_in;
    decinfo_t   dec_out;

    decode_class_if cls_if ();

    inst_fetch u_fetch (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_wb_dat    (i_wb_dat),
        .i_wb_ack    (i_wb_ack),
        .i_slot_free (!fq_valid),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_adr    (o_wb_adr),
        .o_valid     (fetch_valid),
        .o_pkt       (fetch_pkt)
    );

    // fetch only issues into an empty slot, so its ready is never needed
    pipe_reg #(.payload_t(fetch_pkt_t)) u_fetch_q (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (fetch_valid),
        .i_data   (fetch_pkt),
        .o_ready  (),
        .o_valid  (fq_valid),
        .o_data   (fq_pkt),
        .i_ready  (dq_ready)
    );

    inst_classifier u_classifier (
        .i_pkt (fq_pkt),
        .o_cls (cls_if.producer)
    );

    imm_gen u_imm_gen (
        .i_cls (cls_if.consumer),
        .o_imm (dec_in.imm)
    );

    uop_select u_uop_select (
        .i_cls     (cls_if.consumer),
        .o_uop     (dec_in.uop),
        .o_queue   (dec_in.queue),
        .o_rd_wen  (dec_in.rd_wen),
        .o_use_imm (dec_in.use_imm),
        .o_rs1_idx (dec_in.rs1_idx),
        .o_rs2_idx (dec_in.rs2_idx),
        .o_unknown (dec_in.unknown)
    );

    assign dec_in.pc = fq_pkt.pc;
    assign dec_in.rd_idx = cls_if.rd_idx;

    pipe_reg #(.payload_t(decinfo_t)) u_dec_q (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (fq_valid),
        .i_data   (dec_in),
        .o_ready  (dq_ready),
        .o_valid  (o_dec_valid),
        .o_data   (dec_out),
        .i_ready  (i_dec_ready)
    );

    assign o_dec_pc = dec_out.pc;
    assign o_dec_imm = dec_out.imm;
    assign o_dec_rd_idx = dec_out.rd_idx;
    assign o_dec_rs1_idx = dec_out.rs1_idx;
    assign o_dec_rs2_idx = dec_out.rs2_idx;
    assign o_dec_rd_wen = dec_out.rd_wen;
    assign o_dec_use_imm = dec_out.use_imm;
    assign o_dec_uop = dec_out.uop;
    assign o_dec_queue = dec_out.queue;
    assign o_dec_unknown = dec_out.unknown;

endmodule

`default_nettype wire

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module tb_decode_stage;
    import uarch_pkg::*;

    localparam int timeout_cycles = 200;
    // major opcodes used to build test words
    localparam int op_reg = 'h33;
    localparam int op_imm = 'h13;
    localparam int op_reg32 = 'h3b;
    localparam int op_imm32 = 'h1b;
    localparam int op_load = 'h03;
    localparam int op_jalr = 'h67;
    localparam int op_lui = 'h37;
    localparam int op_auipc = 'h17;
    localparam int op_store = 'h23;
    localparam int op_branch = 'h63;
    localparam int op_jal = 'h6f;

    logic                  clk = 1'b0;
    logic                  arst_n = 1'b0;
    logic [`INST_W-1:0]    wb_dat = '0;
    logic                  wb_ack = 1'b0;
    logic                  dec_ready = 1'b0;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [`PC_W-1:0]      wb_adr;
    logic                  dec_valid;
    logic [`PC_W-1:0]      dec_pc;
    logic [`IMM_W-1:0]     dec_imm;
    logic [`REG_IDX_W-1:0] dec_rd_idx;
    logic [`REG_IDX_W-1:0] dec_rs1_idx;
    logic [`REG_IDX_W-1:0] dec_rs2_idx;
    logic                  dec_rd_wen;
    logic                  dec_use_imm;
    uop_e                  dec_uop;
    issue_queue_e          dec_queue;
    logic                  dec_unknown;

    // program words and the micro-op each one should become
    logic [31:0] prog [0:63];
    uop_e        prog_uop [0:63];
    int          n_prog = 0;
    int          wait_left = 0;
    logic [31:0] mem_rng = 32'hc42e_10a7;
    logic [31:0] rdy_rng = 32'hc42e_10a7;

    decode_stage DUT (
        .i_clk(clk), .i_arst_n(arst_n),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
        .i_wb_dat(wb_dat), .i_wb_ack(wb_ack),
        .o_dec_valid(dec_valid), .i_dec_ready(dec_ready), .o_dec_pc(dec_pc),
        .o_dec_imm(dec_imm), .o_dec_rd_idx(dec_rd_idx), .o_dec_rs1_idx(dec_rs1_idx),
        .o_dec_rs2_idx(dec_rs2_idx), .o_dec_rd_wen(dec_rd_wen), .o_dec_use_imm(dec_use_imm),
        .o_dec_uop(dec_uop), .o_dec_queue(dec_queue), .o_dec_unknown(dec_unknown)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_word(input int f7, rs2, rs1, f3, rd, opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction
    function automatic logic [31:0] i_word(input int imm, rs1, f3, rd, opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction
    function automatic logic [31:0] s_word(input int imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction
    function automatic logic [31:0] b_word(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction
    function automatic logic [31:0] u_word(input int imm, rd, opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction
    function automatic logic [31:0] j_word(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // words past the program are compressed-looking fill, unique per address
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        logic [31:0] off;
        off = adr - `RESET_PC;
        if (off < 32'(4 * n_prog)) begin
            return prog[off[7:2]];
        end
        return {adr[31:2] ^ 30'(adr[1:0]), 2'b00};
    endfunction

    // expected fields from the format, queue and masking rules
    function automatic decinfo_t ref_decode(input logic [31:0] inst, input logic [31:0] pc,
                                            input uop_e uop);
        decinfo_t    d;
        logic [19:0] imm_i;
        d = '0;
        imm_i = {{8{inst[31]}}, inst[31:20]};
        d.pc = pc;
        d.rd_idx = inst[11:7];
        d.uop = uop;
        d.unknown = (uop == uop_none);
        if (uop == uop_none) d.queue = iq_none;
        else if (uop <= uop_sltu) d.queue = iq_alu;
        else if (uop <= uop_remuw) d.queue = iq_mdu;
        else if (uop <= uop_jalr) d.queue = iq_bru;
        else d.queue = iq_mem;
        if (!d.unknown) begin
            d.rs1_idx = inst[19:15];
            d.rs2_idx = inst[24:20];
            d.rd_wen = (inst[11:7] != 5'd0);
            case (32'(inst[6:0]))
                op_lui, op_auipc: begin
                    d.imm = inst[31:12];
                    d.rs1_idx = '0;
                    d.rs2_idx = '0;
                end
                op_jal: begin
                    d.imm = {inst[19:12], inst[20], inst[30:21], 1'b0};
                    d.rs1_idx = '0;
                    d.rs2_idx = '0;
                end
                op_jalr, op_load: begin
                    d.imm = imm_i;
                    d.rs2_idx = '0;
                end
                op_store: begin
                    d.imm = {{8{inst[31]}}, inst[31:25], inst[11:7]};
                    d.rd_wen = 1'b0;
                end
                op_branch: begin
                    d.imm = {{8{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    d.rd_wen = 1'b0;
                end
                op_imm, op_imm32: begin
                    // funct3 1 and 5 are shifts
                    d.imm = (inst[13:12] == 2'b01) ? {14'd0, inst[25:20]} : imm_i;
                    d.use_imm = 1'b1;
                    d.rs2_idx = '0;
                end
                default: d.imm = '0;
            endcase
        end
        return d;
    endfunction

    // memory model, 0 to 3 wait states before each ack
    always @(negedge clk) begin
        if (!arst_n || wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 0) begin
                wb_ack <= 1'b1;
                wb_dat <= fetch_word(wb_adr);
                mem_rng = lcg(mem_rng);
                wait_left <= int'(mem_rng[17:16]);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", timeout_cycles, what);
        $display("Checks failed");
        $fatal(1, "timeout");
    endtask

    task automatic add_inst(input logic [31:0] inst, input uop_e u);
        prog[n_prog] = inst;
        prog_uop[n_prog] = u;
        n_prog = n_prog + 1;
    endtask

    task automatic apply_reset();
        int waited;
        waited = 0;
        @(negedge clk);
        arst_n = 1'b0;
        dec_ready = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check("o_wb_cyc", 64'(1'b0), 64'(wb_cyc));
            check("o_wb_stb", 64'(1'b0), 64'(wb_stb));
            check("o_dec_valid", 64'(1'b0), 64'(dec_valid));
        end
        arst_n = 1'b1;
        // no word has been acked yet one clock after release
        @(negedge clk);
        check("o_dec_valid", 64'(1'b0), 64'(dec_valid));
        while (!wb_stb) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > timeout_cycles) report_timeout("the first bus cycle");
        end
        check("o_wb_adr", 64'(`RESET_PC), 64'(wb_adr));
    endtask

    task automatic take_output(input decinfo_t e, input bit random_ready);
        int waited;
        waited = 0;
        while (1) begin
            @(negedge clk);
            rdy_rng = lcg(rdy_rng);
            dec_ready = random_ready ? rdy_rng[20] : 1'b1;
            if (dec_valid && dec_ready) break;
            waited = waited + 1;
            if (waited > timeout_cycles) report_timeout("a decoded micro-op");
        end
        check("o_dec_pc", 64'(e.pc), 64'(dec_pc));
        check("o_dec_imm", 64'(e.imm), 64'(dec_imm));
        check("o_dec_rd_idx", 64'(e.rd_idx), 64'(dec_rd_idx));
        check("o_dec_rs1_idx", 64'(e.rs1_idx), 64'(dec_rs1_idx));
        check("o_dec_rs2_idx", 64'(e.rs2_idx), 64'(dec_rs2_idx));
        check("o_dec_rd_wen", 64'(e.rd_wen), 64'(dec_rd_wen));
        check("o_dec_use_imm", 64'(e.use_imm), 64'(dec_use_imm));
        check("o_dec_uop", 64'(e.uop), 64'(dec_uop));
        check("o_dec_queue", 64'(e.queue), 64'(dec_queue));
        check("o_dec_unknown", 64'(e.unknown), 64'(dec_unknown));
    endtask

    task automatic run_program(input bit random_ready);
        int i;
        apply_reset();
        for (i = 0; i < n_prog; i++) begin
            take_output(ref_decode(prog[i], `RESET_PC + 32'(4 * i), prog_uop[i]), random_ready);
        end
        @(negedge clk);
        dec_ready = 1'b0;
    endtask

    task automatic reset_behavior();
        n_prog = 0;
        apply_reset();
    endtask

    task automatic integer_ops(input bit run_now);
        if (run_now) n_prog = 0;
        add_inst(r_word(0, 3, 2, 0, 1, op_reg), uop_add);
        add_inst(r_word(32, 6, 5, 0, 4, op_reg), uop_sub);
        add_inst(r_word(32, 9, 8, 5, 7, op_reg), uop_sra);
        add_inst(r_word(0, 12, 11, 3, 10, op_reg), uop_sltu);
        add_inst(r_word(0, 2, 1, 7, 0, op_reg), uop_and);
        add_inst(i_word(-7, 6, 0, 5, op_imm), uop_add);
        add_inst(i_word(85, 2, 4, 1, op_imm), uop_xor);
        add_inst(i_word(33, 4, 1, 3, op_imm), uop_sll);
        add_inst(i_word(1087, 4, 5, 3, op_imm), uop_sra);
        // immediate bit 10 sits where funct7 alt would be
        add_inst(i_word(1024, 1, 0, 1, op_imm), uop_add);
        add_inst(r_word(0, 3, 2, 0, 1, op_reg32), uop_addw);
        add_inst(r_word(32, 3, 2, 0, 1, op_reg32), uop_subw);
        add_inst(r_word(32, 3, 2, 5, 1, op_reg32), uop_sraw);
        add_inst(i_word(-1, 2, 0, 1, op_imm32), uop_addw);
        add_inst(i_word(5, 2, 5, 1, op_imm32), uop_srlw);
        add_inst(r_word(1, 3, 2, 0, 1, op_reg), uop_mul);
        add_inst(r_word(1, 3, 2, 2, 1, op_reg), uop_mulhsu);
        add_inst(r_word(1, 3, 2, 5, 1, op_reg), uop_divu);
        add_inst(r_word(1, 3, 2, 6, 1, op_reg32), uop_remw);
        add_inst(r_word(1, 3, 2, 5, 1, op_reg32), uop_divuw);
        if (run_now) run_program(1'b0);
    endtask

    task automatic control_and_memory(input bit run_now);
        if (run_now) n_prog = 0;
        add_inst(u_word('habcde, 1, op_lui), uop_lui);
        add_inst(u_word('h80001, 2, op_auipc), uop_auipc);
        add_inst(i_word(-16, 4, 3, 3, op_load), uop_ld);
        add_inst(i_word(2047, 6, 4, 5, op_load), uop_lbu);
        add_inst(i_word(8, 6, 6, 5, op_load), uop_lwu);
        add_inst(s_word(-8, 7, 8, 3), uop_sd);
        add_inst(s_word(5, 1, 2, 0), uop_sb);
        add_inst(b_word(-4096, 2, 1, 0), uop_beq);
        add_inst(b_word(22, 4, 3, 7), uop_bgeu);
        add_inst(b_word(-2, 6, 5, 4), uop_blt);
        add_inst(j_word(2048, 1), uop_jal);
        add_inst(j_word(-2, 0), uop_jal);
        add_inst(i_word(12, 5, 0, 1, op_jalr), uop_jalr);
        if (run_now) run_program(1'b0);
    endtask

    task automatic unknown_words(input bit run_now);
        if (run_now) n_prog = 0;
        add_inst(32'h0000_4501, uop_none);
        add_inst(r_word(0, 3, 2, 0, 1, 'h53), uop_none);
        add_inst(i_word('h300, 1, 1, 2, 'h73), uop_none);
        add_inst(32'h0000_0073, uop_none);
        add_inst(32'h0ff0_000f, uop_none);
        add_inst(r_word(2, 3, 2, 0, 1, op_reg), uop_none);
        add_inst(r_word(32, 3, 2, 4, 1, op_reg), uop_none);
        add_inst(r_word(1, 3, 2, 1, 1, op_reg32), uop_none);
        add_inst(i_word(0, 2, 7, 1, op_load), uop_none);
        add_inst(s_word(0, 1, 2, 4), uop_none);
        add_inst(b_word(8, 2, 1, 2), uop_none);
        if (run_now) run_program(1'b0);
    endtask

    task automatic backpressure_order();
        n_prog = 0;
        integer_ops(1'b0);
        control_and_memory(1'b0);
        unknown_words(1'b0);
        run_program(1'b1);
    endtask

    initial begin
        reset_behavior();
        integer_ops(1'b1);
        control_and_memory(1'b1);
        unknown_words(1'b1);
        backpressure_order();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/uarch_pkg.sv
logic/decode_class_if.sv
logic/pipe_reg.sv
logic/inst_fetch.sv
logic/inst_classifier.sv
logic/imm_gen.sv
logic/uop_select.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_decode_stage -o tb_sim
# the log decides pass or fail
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Checks failed" sim.log; then
    exit 1
fi
grep -q "All checks passed" sim.log
